//--- design/eda_pkg.sv
package eda_pkg;

  // Window geometry
  localparam int WINDOW_W      = 3;                      // 3x3 pixel window
  localparam int NUM_NEIGHBORS = WINDOW_W * WINDOW_W - 1; // All cells except the centre

  // Address and queue sizing
  localparam int ADDR_W     = 12;                 // Pixel address width
  localparam int FIFO_DEPTH = 8;                  // Entries per queue, power of two
  localparam int PTR_W      = $clog2(FIFO_DEPTH); // Read and write pointer width

  typedef logic [ADDR_W-1:0] pixel_addr_t; // One pixel address

  // Neighbour index, also the bit position in every mask
  // Lower value wins in the output priority chains
  typedef enum logic [2:0] {
    NBR_DOWNRIGHT = 3'd0, // Highest priority
    NBR_DOWN      = 3'd1,
    NBR_DOWNLEFT  = 3'd2,
    NBR_RIGHT     = 3'd3,
    NBR_LEFT      = 3'd4,
    NBR_UPRIGHT   = 3'd5,
    NBR_UP        = 3'd6,
    NBR_UPLEFT    = 3'd7  // Lowest priority
  } neighbor_e;

  // One bit per neighbour, upleft in the MSB
  typedef struct packed {
    logic upleft;    // Bit 7
    logic up;        // Bit 6
    logic upright;   // Bit 5
    logic left;      // Bit 4
    logic right;     // Bit 3
    logic downleft;  // Bit 2
    logic down;      // Bit 1
    logic downright; // Bit 0
  } nbr_mask_t;

  // One address per neighbour, same order as nbr_mask_t
  typedef struct packed {
    pixel_addr_t upleft;    // Slot 7
    pixel_addr_t up;        // Slot 6
    pixel_addr_t upright;   // Slot 5
    pixel_addr_t left;      // Slot 4
    pixel_addr_t right;     // Slot 3
    pixel_addr_t downleft;  // Slot 2
    pixel_addr_t down;      // Slot 1
    pixel_addr_t downright; // Slot 0
  } nbr_addr_t;

endpackage : eda_pkg

//--- design/neighbor_fifo.sv
`timescale 1ns/1ps

// Circular address queue for one neighbour of the window.
// The parent feeds the inverted clock, so every update here lands on
// the falling edge of the system clock.
module neighbor_fifo (
  input  logic                 i_clk,   // Inverted system clock
  input  logic                 i_rst_n, // Synchronous, active low
  input  logic                 i_push,  // Store i_addr this edge
  input  logic                 i_read,  // Drop the head this edge
  input  eda_pkg::pixel_addr_t i_addr,  // Address to store
  output logic                 o_empty, // No entries held
  output eda_pkg::pixel_addr_t o_head   // Oldest entry
);

  localparam int CNT_W = eda_pkg::PTR_W + 1; // Count reaches FIFO_DEPTH

  eda_pkg::pixel_addr_t           mem [eda_pkg::FIFO_DEPTH]; // Entry storage
  logic [eda_pkg::PTR_W-1:0]      wr_ptr;                    // Next free slot
  logic [eda_pkg::PTR_W-1:0]      rd_ptr;                    // Current head slot
  logic [CNT_W-1:0]               count;                     // Entries held
  logic                           full;                      // All slots used
  logic                           empty;                     // No slot used
  logic                           wr_en;                     // Qualified push
  logic                           rd_en;                     // Qualified read

  assign full  = (count == CNT_W'(eda_pkg::FIFO_DEPTH)); // Depth reached
  assign empty = (count == '0);                          // Nothing stored

  // Read of an empty queue is dropped, so push alone wins there
  assign rd_en = i_read && !empty;

  // Full queue takes a push only when a read frees the head slot
  assign wr_en = i_push && (!full || i_read);

  // Storage write, no reset on payload
  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_addr; // Overwrites the popped head when full
    end
  end

  // Pointer and occupancy control
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1; // Power-of-two depth wraps naturally
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1; // Advance to next oldest
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1; // Store only
        2'b01:   count <= count - 1'b1; // Pop only
        default: count <= count;        // Both or neither
      endcase
    end
  end

  // Head is always visible, stale data when empty
  assign o_head  = mem[rd_ptr];
  assign o_empty = empty; // Flag settles half a cycle after inputs

endmodule : neighbor_fifo

//--- design/neighbor_select.sv
`timescale 1ns/1ps

// Output address picker for the eight neighbour queues.
// Held entries always beat addresses that are only being pushed.
module neighbor_select (
  input  eda_pkg::nbr_addr_t   i_heads,   // Queue heads
  input  eda_pkg::nbr_mask_t   i_empty,   // Queue empty flags
  input  eda_pkg::nbr_mask_t   i_push,    // Push strobes this cycle
  input  eda_pkg::nbr_addr_t   i_addrs,   // Addresses being pushed
  output eda_pkg::pixel_addr_t o_data_out // Chosen address
);

  logic                 [eda_pkg::NUM_NEIGHBORS-1:0] empty_v; // Empty flags by index
  logic                 [eda_pkg::NUM_NEIGHBORS-1:0] push_v;  // Push strobes by index
  eda_pkg::pixel_addr_t [eda_pkg::NUM_NEIGHBORS-1:0] heads_v; // Heads by index
  eda_pkg::pixel_addr_t [eda_pkg::NUM_NEIGHBORS-1:0] addrs_v; // Pushed addrs by index

  logic                 head_hit; // Some queue holds data
  eda_pkg::pixel_addr_t head_sel; // Head of best non-empty queue
  eda_pkg::pixel_addr_t push_sel; // Address of best pushing neighbour

  // Struct fields line up with neighbor_e bit positions
  assign empty_v = i_empty;
  assign push_v  = i_push;
  assign heads_v = i_heads;
  assign addrs_v = i_addrs;

  // Chain over queue heads
  // Walks upleft to downright, so the last hit is the highest priority
  always_comb begin : proc_head_chain
    eda_pkg::neighbor_e nbr;
    nbr      = eda_pkg::NBR_UPLEFT;
    head_hit = 1'b0;
    head_sel = '0;
    for (int i = eda_pkg::NUM_NEIGHBORS - 1; i >= 0; i--) begin
      nbr = eda_pkg::neighbor_e'(i);
      if (!empty_v[nbr]) begin
        head_hit = 1'b1;         // At least one queue has an entry
        head_sel = heads_v[nbr]; // Lower index overrides
      end
    end
  end

  // Chain over incoming pushes, used only when every queue is empty
  always_comb begin : proc_push_chain
    eda_pkg::neighbor_e nbr;
    nbr      = eda_pkg::NBR_UPLEFT;
    push_sel = '0; // Zero when nothing is pushed
    for (int i = eda_pkg::NUM_NEIGHBORS - 1; i >= 0; i--) begin
      nbr = eda_pkg::neighbor_e'(i);
      if (push_v[nbr]) begin
        push_sel = addrs_v[nbr]; // Same priority order as the heads
      end
    end
  end

  // Stored entries first, then the bypass of this cycle's pushes
  assign o_data_out = head_hit ? head_sel : push_sel;

endmodule : neighbor_select

//--- design/eda_fifos.sv
`timescale 1ns/1ps

// Neighbour address queues for the 3x3 tracing window
//
//   upleft/7   | up/6   | upright/5
//   left/4     | centre | right/3
//   downleft/2 | down/1 | downright/0
//
// Index is the bit position in every mask and the slot in every
// address struct. Queues run on the falling edge of i_clk.
module eda_fifos (
  input  logic                 i_clk,        // System clock
  input  logic                 i_rst_n,      // Synchronous, active low
  input  eda_pkg::nbr_mask_t   i_push,       // Push strobe per neighbour
  input  eda_pkg::nbr_mask_t   i_read_en,    // Read strobe per neighbour
  input  eda_pkg::nbr_addr_t   i_addrs,      // Address per neighbour
  output eda_pkg::nbr_mask_t   o_fifo_empty, // Empty flag per neighbour
  output eda_pkg::pixel_addr_t o_data_out    // Priority-selected address
);

  logic inv_clk; // Queue clock, rising on the falling edge of i_clk

  logic                 [eda_pkg::NUM_NEIGHBORS-1:0] push_v;  // Push bits by index
  logic                 [eda_pkg::NUM_NEIGHBORS-1:0] read_v;  // Read bits by index
  eda_pkg::pixel_addr_t [eda_pkg::NUM_NEIGHBORS-1:0] addr_v;  // Input addrs by index
  logic                 [eda_pkg::NUM_NEIGHBORS-1:0] empty_v; // Empty flags by index
  eda_pkg::pixel_addr_t [eda_pkg::NUM_NEIGHBORS-1:0] head_v;  // Queue heads by index

  eda_pkg::nbr_addr_t heads; // Heads packed for the selector
  eda_pkg::nbr_mask_t empty; // Empties packed for output and selector

  assign inv_clk = ~i_clk;

  // Split input structs into indexable vectors
  assign push_v = i_push;
  assign read_v = i_read_en;
  assign addr_v = i_addrs;

  // One queue per neighbour
  for (genvar g = 0; g < eda_pkg::NUM_NEIGHBORS; g++) begin : gen_nbr
    localparam eda_pkg::neighbor_e NBR = eda_pkg::neighbor_e'(g); // Window position

    neighbor_fifo u_fifo (
      .i_clk   (inv_clk),      // Falling-edge update
      .i_rst_n (i_rst_n),
      .i_push  (push_v[NBR]),
      .i_read  (read_v[NBR]),
      .i_addr  (addr_v[NBR]),
      .o_empty (empty_v[NBR]),
      .o_head  (head_v[NBR])
    );
  end

  // Collect per-queue results back into structs
  assign heads = head_v;
  assign empty = empty_v;

  neighbor_select u_select (
    .i_heads    (heads),
    .i_empty    (empty),
    .i_push     (i_push),     // Bypass uses the raw strobes
    .i_addrs    (i_addrs),
    .o_data_out (o_data_out)  // Zero latency from heads and pushes
  );

  assign o_fifo_empty = empty; // All ones after reset

endmodule : eda_fifos

//--- tb/eda_fifos_asserts.sv
`timescale 1ns/1ps

module eda_fifos_asserts (
  input logic                 i_clk,
  input logic                 i_rst_n,
  input eda_pkg::nbr_mask_t   i_push,
  input eda_pkg::nbr_mask_t   o_fifo_empty,
  input eda_pkg::pixel_addr_t o_data_out
);

  int assert_errors = 0; // Failure count, summed into the final verdict

  logic [eda_pkg::NUM_NEIGHBORS-1:0] push_v;  // Push strobes by index
  logic [eda_pkg::NUM_NEIGHBORS-1:0] empty_v; // Empty flags by index

  assign push_v  = i_push;
  assign empty_v = o_fifo_empty;

  // Two low samples in a row enclose a falling edge with reset applied
  a_reset_empty: assert property (@(posedge i_clk)
      (!i_rst_n && $past(!i_rst_n)) |-> (empty_v == '1))
    else begin
      $error("Queues not all empty after reset");
      assert_errors++;
    end

  // Strobes are still held at the rising edge that follows the update
  for (genvar g = 0; g < eda_pkg::NUM_NEIGHBORS; g++) begin : gen_fill
    a_fill_by_push: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(empty_v[g]) |-> push_v[g])
      else begin
        $error("Empty flag %0d cleared without a push", g);
        assert_errors++;
      end
  end

  a_idle_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      ((empty_v == '1) && (push_v == '0)) |-> (o_data_out == '0))
    else begin
      $error("Output not zero with all queues empty and no push");
      assert_errors++;
    end

endmodule : eda_fifos_asserts

bind eda_fifos eda_fifos_asserts u_asserts (.*);

//--- tb/tb_eda_fifos.sv
`timescale 1ns/1ps

module tb_eda_fifos;

  localparam int CLK_PERIOD = 100;  // ns
  localparam int RST_CYCLES = 16;   // Reset hold in clocks
  localparam int N_CYCLES   = 2000; // Random stimulus length
  localparam int DRIVE_DLY  = 5;    // Input skew after the rising edge
  localparam int PHASE_LEN  = 250;  // Cycles per density phase
  localparam int NUM        = eda_pkg::NUM_NEIGHBORS;
  localparam int DEPTH      = eda_pkg::FIFO_DEPTH;

  logic                 i_clk = 1'b0;
  logic                 i_rst_n;
  eda_pkg::nbr_mask_t   i_push;
  eda_pkg::nbr_mask_t   i_read_en;
  eda_pkg::nbr_addr_t   i_addrs;
  eda_pkg::nbr_mask_t   o_fifo_empty;
  eda_pkg::pixel_addr_t o_data_out;

  integer seed = 32'hd62df81e; // Fixed seed for $random

  // One reference circular buffer per neighbour
  eda_pkg::pixel_addr_t model_mem [NUM][DEPTH];
  int model_hd  [NUM];
  int model_cnt [NUM];

  int mask_errors  = 0;
  int addr_errors  = 0;
  int other_errors = 0;
  int full_drops   = 0; // Pushes lost to a full queue
  int empty_reads  = 0; // Reads of an empty queue

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  eda_fifos uut (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_push       (i_push),
    .i_read_en    (i_read_en),
    .i_addrs      (i_addrs),
    .o_fifo_empty (o_fifo_empty),
    .o_data_out   (o_data_out)
  );

  // Model tracks the queues on the same edge as the DUT
  always @(negedge i_clk) begin : model_update
    logic [NUM-1:0]                 push_b;
    logic [NUM-1:0]                 read_b;
    eda_pkg::pixel_addr_t [NUM-1:0] addr_b;
    logic                           do_rd;
    logic                           do_wr;
    push_b = i_push;
    read_b = i_read_en;
    addr_b = i_addrs;
    for (int n = 0; n < NUM; n++) begin
      if (!i_rst_n) begin
        model_hd[n]  = 0;
        model_cnt[n] = 0;
      end
      else begin
        do_rd = read_b[n] && (model_cnt[n] != 0);                // Empty read dropped
        do_wr = push_b[n] && ((model_cnt[n] != DEPTH) || read_b[n]); // Full push dropped
        if (push_b[n] && !do_wr) full_drops++;
        if (read_b[n] && model_cnt[n] == 0) empty_reads++;
        if (do_wr) begin
          model_mem[n][(model_hd[n] + model_cnt[n]) % DEPTH] = addr_b[n]; // Tail slot
        end
        if (do_rd) model_hd[n] = (model_hd[n] + 1) % DEPTH;
        model_cnt[n] = model_cnt[n] + int'(do_wr) - int'(do_rd);
      end
    end
  end

  task automatic check_mask(input string name, input eda_pkg::nbr_mask_t exp,
                            input eda_pkg::nbr_mask_t act);
    if (act !== exp) begin
      mask_errors++;
      $display("FAILED %s at %0t: expected %b, actual %b", name, $time, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input eda_pkg::pixel_addr_t exp,
                            input eda_pkg::pixel_addr_t act);
    if (act !== exp) begin
      addr_errors++;
      $display("FAILED %s at %0t: expected %h, actual %h", name, $time, exp, act);
    end
  endtask

  // Expected outputs from the model state and the inputs still applied
  task automatic predict_outputs(output eda_pkg::nbr_mask_t exp_empty,
                                 output eda_pkg::pixel_addr_t exp_data,
                                 output string label);
    logic [NUM-1:0]                 empty_b;
    logic [NUM-1:0]                 push_b;
    eda_pkg::pixel_addr_t [NUM-1:0] addr_b;
    logic                           found;
    push_b   = i_push;
    addr_b   = i_addrs;
    found    = 1'b0;
    exp_data = '0;
    label    = "idle_zero";
    for (int n = 0; n < NUM; n++) empty_b[n] = (model_cnt[n] == 0);
    exp_empty = eda_pkg::nbr_mask_t'(empty_b);
    // Priority runs from downright to upleft
    for (int n = eda_pkg::NBR_DOWNRIGHT; n <= eda_pkg::NBR_UPLEFT; n++) begin
      if (!found && model_cnt[n] != 0) begin
        found    = 1'b1;
        exp_data = model_mem[n][model_hd[n]];
        label    = "priority_head";
      end
    end
    for (int n = eda_pkg::NBR_DOWNRIGHT; n <= eda_pkg::NBR_UPLEFT; n++) begin
      if (!found && push_b[n]) begin
        found    = 1'b1; // Bypass only when every queue is empty
        exp_data = addr_b[n];
        label    = "bypass";
      end
    end
  endtask

  task automatic check_outputs(input string tag);
    eda_pkg::nbr_mask_t   exp_empty;
    eda_pkg::pixel_addr_t exp_data;
    string                label;
    predict_outputs(exp_empty, exp_data, label);
    check_mask($sformatf("%s/empty_mask", tag), exp_empty, o_fifo_empty);
    check_addr($sformatf("%s/%s", tag, label), exp_data, o_data_out);
  endtask

  // Density shifts by phase so queues both fill up and drain
  task automatic drive_random(input int cyc);
    int                             phase;
    int                             push_th;
    int                             read_th;
    logic [NUM-1:0]                 push_b;
    logic [NUM-1:0]                 read_b;
    eda_pkg::pixel_addr_t [NUM-1:0] addr_b;
    phase = (cyc / PHASE_LEN) % 4;
    case (phase)
      0: begin // Balanced
        push_th = 4;
        read_th = 4;
      end
      1: begin // Fill toward full
        push_th = 7;
        read_th = 1;
      end
      2: begin // Drain toward empty
        push_th = 1;
        read_th = 7;
      end
      default: begin // Sparse traffic exercises the bypass
        push_th = 2;
        read_th = 2;
      end
    endcase
    for (int n = 0; n < NUM; n++) begin
      push_b[n] = ($unsigned($random(seed)) % 8) < push_th;
      read_b[n] = ($unsigned($random(seed)) % 8) < read_th;
      addr_b[n] = eda_pkg::pixel_addr_t'($random(seed));
    end
    i_push    = eda_pkg::nbr_mask_t'(push_b);
    i_read_en = eda_pkg::nbr_mask_t'(read_b);
    i_addrs   = addr_b;
  endtask

  initial begin : main
    int total;
    i_rst_n   = 1'b0;
    i_push    = '0;
    i_read_en = '0;
    i_addrs   = '0;
    repeat (RST_CYCLES) @(posedge i_clk);
    #(DRIVE_DLY) i_rst_n = 1'b1;
    @(posedge i_clk);
    check_mask("after_reset", '1, o_fifo_empty); // Every queue cleared
    check_addr("after_reset", '0, o_data_out);   // No push and no entries
    for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
      #(DRIVE_DLY) drive_random(cyc);
      @(posedge i_clk);
      check_outputs($sformatf("cycle_%0d", cyc));
    end
    if (full_drops == 0) begin
      other_errors++;
      $display("ERROR: no push ever reached a full queue");
    end
    if (empty_reads == 0) begin
      other_errors++;
      $display("ERROR: no read of an empty queue was ever driven");
    end
    total = mask_errors + addr_errors + other_errors + uut.u_asserts.assert_errors;
    $display("Errors: mask %0d, addr %0d, other %0d, assertions %0d (full drops %0d)",
             mask_errors, addr_errors, other_errors, uut.u_asserts.assert_errors,
             full_drops);
    if (total == 0) begin
      $display("Regression passed");
    end
    else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Upper bound on run length with a few spare cycles past the stimulus
  initial begin : watchdog
    #((N_CYCLES + RST_CYCLES + 10) * CLK_PERIOD);
    $display("ERROR: the run timed out before all cycles completed");
    $display("Regression failed");
    $finish;
  end

endmodule : tb_eda_fifos

//--- tb.f
design/eda_pkg.sv
design/neighbor_fifo.sv
design/neighbor_select.sv
design/eda_fifos.sv
tb/eda_fifos_asserts.sv
tb/tb_eda_fifos.sv
